//--- design/fpu_config.svh
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// single-precision field layout
`define FPU_EXP_WIDTH   8
`define FPU_FRAC_WIDTH  23

// exponent offset of a normal number
`define FPU_EXP_BIAS    127

// architectural register count
`define FPU_REG_COUNT   32

// special results
// returned by every invalid case, positive, fraction 1
`define FPU_NAN_WORD    32'h7f80_0001
// sign bit patched in by the units
`define FPU_INF_WORD    32'h7f80_0000

`endif

//--- design/fpu_pkg.sv
`include "fpu_config.svh"

package fpu_pkg;

    // reference numbering kept, 7 to 12 have no unit and run as idle
    typedef enum logic [3:0]
    {
        op_idle   = 4'd0,
        op_adds   = 4'd1,
        op_addps  = 4'd2,
        op_subs   = 4'd3,
        op_subps  = 4'd4,
        op_muls   = 4'd5,
        op_mulps  = 4'd6,
        op_divs   = 4'd7,
        op_cvtpss = 4'd8,
        op_cvtsw  = 4'd9,
        op_cvtws  = 4'd10,
        op_cvtspl = 4'd11,
        op_cvtspu = 4'd12,
        op_mfc1   = 4'd13,
        op_mtc1   = 4'd14
    } fpu_op_t;

    typedef logic [`FPU_EXP_WIDTH+`FPU_FRAC_WIDTH:0] fp_word_t;

    // upper word is the even register
    typedef logic [2*(`FPU_EXP_WIDTH+`FPU_FRAC_WIDTH+1)-1:0] fp_pair_t;

    typedef logic [$clog2(`FPU_REG_COUNT)-1:0] reg_index_t;

endpackage

//--- design/fp_adder.sv
`include "fpu_config.svh"

module fp_adder
(
    input  fpu_pkg::fp_word_t a,
    input  fpu_pkg::fp_word_t b,
    output fpu_pkg::fp_word_t sum,
    output logic              exception
);
    import fpu_pkg::*;

    localparam fp_word_t inf_word = `FPU_INF_WORD;

    fp_word_t          big, lesser;
    logic [30:0]       a_mag, b_mag;       // subnormals count as zero
    logic [23:0]       big_sig, small_sig;
    logic [7:0]        exp_diff;
    logic              eff_sub;
    logic [49:0]       shifted;
    logic [26:0]       aligned;            // significand, guard, round, sticky
    logic [27:0]       raw_sum;
    logic [4:0]        lead;
    logic [26:0]       norm;
    logic signed [9:0] norm_exp;
    logic              round_up;
    logic [24:0]       rounded;
    logic signed [9:0] final_exp;

    function automatic logic [4:0] lead_one(input logic [27:0] v);
        logic [4:0] pos;
        pos = '0;
        for (int i = 0; i < 28; i++)
        begin
            if (v[i])
            begin
                pos = i[4:0];
            end
        end
        return pos;
    endfunction

    assign a_mag  = (a[30:23] == 8'd0) ? 31'd0 : a[30:0];
    assign b_mag  = (b[30:23] == 8'd0) ? 31'd0 : b[30:0];
    assign big    = (a_mag >= b_mag) ? a : b;
    assign lesser = (a_mag >= b_mag) ? b : a;

    assign big_sig   = (big[30:23] == 8'd0) ? 24'd0 : {1'b1, big[22:0]};
    assign small_sig = (lesser[30:23] == 8'd0) ? 24'd0 : {1'b1, lesser[22:0]};
    assign exp_diff  = big[30:23] - lesser[30:23];
    assign eff_sub   = big[31] ^ lesser[31];

    always_comb
    begin
        shifted = {small_sig, 26'd0} >> exp_diff;
        if (exp_diff > 8'd26)
            aligned = {26'd0, |small_sig};     // only sticky survives
        else
            aligned = {shifted[49:24], |shifted[23:0]};
        raw_sum = eff_sub ? {1'b0, big_sig, 3'b000} - {1'b0, aligned}
                          : {1'b0, big_sig, 3'b000} + {1'b0, aligned};
        lead = lead_one(raw_sum);
        if (lead == 5'd27)
        begin
            norm     = {raw_sum[27:2], raw_sum[1] | raw_sum[0]};  // carry out
            norm_exp = $signed({2'b00, big[30:23]}) + 10'sd1;
        end
        else
        begin
            norm     = raw_sum[26:0] << (5'd26 - lead);
            norm_exp = $signed({2'b00, big[30:23]}) - $signed({5'd0, 5'd26 - lead});
        end
        round_up  = norm[2] & (norm[1] | norm[0] | norm[3]);    // ties to even
        rounded   = {1'b0, norm[26:3]} + {24'd0, round_up};
        final_exp = norm_exp + $signed({9'd0, rounded[24]});
    end

    always_comb
    begin
        exception = 1'b0;
        if ((&a[30:23]) | (&b[30:23]))
        begin
            sum       = `FPU_NAN_WORD;              // nan or infinity in
            exception = 1'b1;
        end
        else if (raw_sum == 28'd0)
            sum = '0;
        else if (final_exp >= 10'sd255)
        begin
            sum       = {big[31], inf_word[30:0]};
            exception = 1'b1;
        end
        else if (final_exp < 10'sd1)
        begin
            sum       = '0;                         // flushed
            exception = 1'b1;
        end
        else
            sum = {big[31], final_exp[7:0], rounded[22:0]};
    end

    always_comb
    begin
        assert (exception || !(&sum[30:23]))
            else $error("adder produced an all-ones exponent without exception");
    end

endmodule

//--- design/fp_multiplier.sv
`include "fpu_config.svh"

module fp_multiplier
(
    input  fpu_pkg::fp_word_t a,
    input  fpu_pkg::fp_word_t b,
    output fpu_pkg::fp_word_t product,
    output logic              exception
);
    import fpu_pkg::*;

    localparam logic signed [9:0] exp_bias = `FPU_EXP_BIAS;
    localparam fp_word_t          inf_word = `FPU_INF_WORD;

    logic              a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
    logic              sign;
    logic [47:0]       prod;
    logic [47:0]       shifted;
    logic              round_up;
    logic [24:0]       rounded;
    logic signed [9:0] prod_exp;

    assign a_nan  = (&a[30:23]) & (|a[22:0]);
    assign b_nan  = (&b[30:23]) & (|b[22:0]);
    assign a_inf  = (&a[30:23]) & ~(|a[22:0]);
    assign b_inf  = (&b[30:23]) & ~(|b[22:0]);
    assign a_zero = (a[30:23] == 8'd0);         // subnormal in, zero
    assign b_zero = (b[30:23] == 8'd0);
    assign sign   = a[31] ^ b[31];

    always_comb
    begin
        prod     = {1'b1, a[22:0]} * {1'b1, b[22:0]};
        shifted  = prod[47] ? prod : prod << 1;  // at most one place
        round_up = shifted[23] & ((|shifted[22:0]) | shifted[24]);
        rounded  = {1'b0, shifted[47:24]} + {24'd0, round_up};
        // rounding carry bumps the exponent before range checks
        prod_exp = $signed({2'b00, a[30:23]}) + $signed({2'b00, b[30:23]}) - exp_bias
                   + $signed({9'd0, prod[47]}) + $signed({9'd0, rounded[24]});
    end

    always_comb
    begin
        exception = 1'b0;
        if (a_nan | b_nan)
        begin
            product   = `FPU_NAN_WORD;
            exception = 1'b1;
        end
        else if ((a_inf & b_zero) | (a_zero & b_inf))
        begin
            product   = `FPU_NAN_WORD;              // inf times zero
            exception = 1'b1;
        end
        else if (a_inf | b_inf)
        begin
            product   = {sign, inf_word[30:0]};
            exception = 1'b1;
        end
        else if (a_zero | b_zero)
            product = {sign, 31'd0};                // signed zero, no exception
        else if (prod_exp >= 10'sd255)
        begin
            product   = {sign, inf_word[30:0]};     // overflow
            exception = 1'b1;
        end
        else if (prod_exp < 10'sd1)
        begin
            product   = '0;
            exception = 1'b1;
        end
        else
            product = {sign, prod_exp[7:0], rounded[22:0]};
    end

    always_comb
    begin
        assert (exception || !(&product[30:23]))
            else $error("multiplier produced an all-ones exponent without exception");
    end

endmodule

//--- design/fp_execute.sv
module fp_execute
(
    input  logic                fpu_clock,
    input  logic                fpu_reset_b,
    input  fpu_pkg::fpu_op_t    fpu_instr,
    input  fpu_pkg::reg_index_t fd,
    input  fpu_pkg::fp_word_t   rs_data,
    input  fpu_pkg::fp_word_t   rs_pair_data,
    input  fpu_pkg::fp_word_t   rt_data,
    input  fpu_pkg::fp_word_t   rt_pair_data,
    output fpu_pkg::reg_index_t wb_index,
    output fpu_pkg::fp_pair_t   wb_data,
    output logic                wb_single,
    output logic                wb_pair,
    output fpu_pkg::fp_word_t   result,
    output logic                exception
);
    import fpu_pkg::*;

    // decode stage
    fpu_op_t    op_q;
    reg_index_t fd_q;
    fp_word_t   rs_q, rs_pair_q, rt_q, rt_pair_q;

    fp_word_t   rt_even, rt_odd;        // second operands after sign flip
    logic       is_sub;
    fp_word_t   add_even, add_odd, mul_even, mul_odd;
    logic       add_even_exc, add_odd_exc, mul_even_exc, mul_odd_exc;

    fp_pair_t   ex_data_d;
    logic       ex_exc_d, ex_single_d, ex_pair_d;
    logic       ex_exc;

    always_ff @(posedge fpu_clock)
    begin
        if (fpu_reset_b)
            op_q <= op_idle;
        else
            op_q <= fpu_instr;
    end

    always_ff @(posedge fpu_clock)
    begin
        fd_q      <= fd;
        rs_q      <= rs_data;
        rs_pair_q <= rs_pair_data;
        rt_q      <= rt_data;
        rt_pair_q <= rt_pair_data;
    end

    assign is_sub  = (op_q == op_subs) || (op_q == op_subps);
    assign rt_even = is_sub ? {~rt_q[31], rt_q[30:0]} : rt_q;
    assign rt_odd  = is_sub ? {~rt_pair_q[31], rt_pair_q[30:0]} : rt_pair_q;

    fp_adder      i_add_even (.a(rs_q),      .b(rt_even), .sum(add_even),     .exception(add_even_exc));
    fp_adder      i_add_odd  (.a(rs_pair_q), .b(rt_odd),  .sum(add_odd),      .exception(add_odd_exc));
    fp_multiplier i_mul_even (.a(rs_q),      .b(rt_q),    .product(mul_even), .exception(mul_even_exc));
    fp_multiplier i_mul_odd  (.a(rs_pair_q), .b(rt_pair_q), .product(mul_odd), .exception(mul_odd_exc));

    always_comb
    begin
        ex_data_d   = '0;
        ex_exc_d    = 1'b0;
        ex_single_d = 1'b0;
        ex_pair_d   = 1'b0;
        case (op_q)
            op_adds, op_subs:
            begin
                ex_data_d   = {32'd0, add_even};   // single result rides the low word
                ex_exc_d    = add_even_exc;
                ex_single_d = 1'b1;
            end
            op_addps, op_subps:
            begin
                ex_data_d = {add_even, add_odd};
                ex_exc_d  = add_even_exc | add_odd_exc;
                ex_pair_d = 1'b1;
            end
            op_muls:
            begin
                ex_data_d   = {32'd0, mul_even};
                ex_exc_d    = mul_even_exc;
                ex_single_d = 1'b1;
            end
            op_mulps:
            begin
                ex_data_d = {mul_even, mul_odd};
                ex_exc_d  = mul_even_exc | mul_odd_exc;
                ex_pair_d = 1'b1;
            end
            default:                               // idle, moves, dropped ops
            begin
                ex_data_d = '0;
            end
        endcase
    end

    always_ff @(posedge fpu_clock)
    begin
        wb_data  <= ex_data_d;
        wb_index <= fd_q;
        ex_exc   <= ex_exc_d;
    end

    always_ff @(posedge fpu_clock)
    begin
        if (fpu_reset_b)
        begin
            wb_single <= 1'b0;
            wb_pair   <= 1'b0;
            result    <= '0;
            exception <= 1'b0;
        end
        else
        begin
            wb_single <= ex_single_d;
            wb_pair   <= ex_pair_d;
            result    <= wb_data[31:0];            // lower lane at writeback
            exception <= ex_exc;
        end
    end

    assert property (@(posedge fpu_clock) disable iff (fpu_reset_b) !(wb_single && wb_pair))
        else $error("single and pair writeback at the same time");

endmodule

//--- design/fpr_file.sv
`include "fpu_config.svh"

module fpr_file
(
    input  logic                fpu_clock,
    input  logic                fpu_reset_b,
    input  fpu_pkg::fpu_op_t    fpu_instr,
    input  fpu_pkg::reg_index_t fs,
    input  fpu_pkg::reg_index_t ft,
    input  fpu_pkg::fp_word_t   data_gpr,
    input  fpu_pkg::reg_index_t wb_index,
    input  fpu_pkg::fp_pair_t   wb_data,
    input  logic                wb_single,
    input  logic                wb_pair,
    output fpu_pkg::fp_word_t   rs_data,
    output fpu_pkg::fp_word_t   rs_pair_data,
    output fpu_pkg::fp_word_t   rt_data,
    output fpu_pkg::fp_word_t   rt_pair_data,
    output fpu_pkg::fp_word_t   data_fpr
);
    import fpu_pkg::*;

    fp_word_t   regs [`FPU_REG_COUNT];
    reg_index_t fs_next, ft_next, wb_next;

    // odd neighbours wrap around at 31
    assign fs_next = fs + 5'd1;
    assign ft_next = ft + 5'd1;
    assign wb_next = wb_index + 5'd1;

    assign rs_data      = regs[fs];
    assign rs_pair_data = regs[fs_next];
    assign rt_data      = regs[ft];
    assign rt_pair_data = regs[ft_next];

    always_ff @(posedge fpu_clock)
    begin
        if (fpu_reset_b)
        begin
            for (int i = 0; i < `FPU_REG_COUNT; i++)
                regs[i] <= '0;
            data_fpr <= '0;
        end
        else
        begin
            if (wb_single)
                regs[wb_index] <= wb_data[31:0];
            if (wb_pair)
            begin
                regs[wb_index] <= wb_data[63:32];
                regs[wb_next]  <= wb_data[31:0];
            end
            if (fpu_instr == op_mtc1)
                regs[fs] <= data_gpr;              // last write wins over writeback
            if (fpu_instr == op_mfc1)
                data_fpr <= regs[fs];
        end
    end

endmodule

//--- design/fpu_top.sv
module fpu_top
(
    input  logic                fpu_clock,
    input  logic                fpu_reset_b,
    input  fpu_pkg::fpu_op_t    fpu_instr,
    input  fpu_pkg::reg_index_t fs,
    input  fpu_pkg::reg_index_t ft,
    input  fpu_pkg::reg_index_t fd,
    input  fpu_pkg::fp_word_t   data_gpr,
    output fpu_pkg::fp_word_t   result,
    output fpu_pkg::fp_word_t   data_fpr,
    output logic                exception
);
    import fpu_pkg::*;

    // operand fetch
    fp_word_t   rs_data, rs_pair_data, rt_data, rt_pair_data;

    // writeback
    reg_index_t wb_index;
    fp_pair_t   wb_data;
    logic       wb_single, wb_pair;

    fpr_file i_fpr_file
    (
        .fpu_clock    (fpu_clock),
        .fpu_reset_b  (fpu_reset_b),
        .fpu_instr    (fpu_instr),
        .fs           (fs),
        .ft           (ft),
        .data_gpr     (data_gpr),
        .wb_index     (wb_index),
        .wb_data      (wb_data),
        .wb_single    (wb_single),
        .wb_pair      (wb_pair),
        .rs_data      (rs_data),
        .rs_pair_data (rs_pair_data),
        .rt_data      (rt_data),
        .rt_pair_data (rt_pair_data),
        .data_fpr     (data_fpr)
    );

    fp_execute i_fp_execute
    (
        .fpu_clock    (fpu_clock),
        .fpu_reset_b  (fpu_reset_b),
        .fpu_instr    (fpu_instr),
        .fd           (fd),
        .rs_data      (rs_data),
        .rs_pair_data (rs_pair_data),
        .rt_data      (rt_data),
        .rt_pair_data (rt_pair_data),
        .wb_index     (wb_index),
        .wb_data      (wb_data),
        .wb_single    (wb_single),
        .wb_pair      (wb_pair),
        .result       (result),
        .exception    (exception)
    );

endmodule

//--- test/fpu_model.svh
`ifndef FPU_MODEL_SVH
`define FPU_MODEL_SVH

`include "fpu_config.svh"

// galois form, one step per bit
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic lsb;
    lsb   = state[0];
    state = state >> 1;
    if (lsb)
        state = state ^ 32'h8020_0003;
    return state;
endfunction

// position of the highest set bit, -1 for zero
function automatic int find_lead(input logic [65:0] v);
    int pos;
    pos = -1;
    for (int i = 0; i < 66; i++)
    begin
        if (v[i])
            pos = i;
    end
    return pos;
endfunction

// keep 24 significant bits below lead, ties to even
function automatic logic [24:0] round_even(input logic [65:0] v, input int lead);
    logic [65:0] keep;
    logic [65:0] rem;
    logic [65:0] half;
    int          sh;
    if (lead <= 23)
        return 25'(v << (23 - lead));   // exact, no bits lost
    sh   = lead - 23;
    keep = v >> sh;
    rem  = v & ((66'd1 << sh) - 66'd1);
    half = 66'd1 << (sh - 1);
    if ((rem > half) || ((rem == half) && keep[0]))
        keep = keep + 66'd1;
    return keep[24:0];
endfunction

// returns {exception, word}
function automatic logic [32:0] ref_add(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] big;
    logic [31:0] lesser;
    logic [30:0] ma, mb;
    logic [23:0] sig_big, sig_small;
    logic [65:0] va, vb, lost, total;
    logic [24:0] r;
    int          diff, lead, e;
    if ((a[30:23] == 8'hff) || (b[30:23] == 8'hff))
        return {1'b1, 32'(`FPU_NAN_WORD)};
    ma     = (a[30:23] == 8'd0) ? 31'd0 : a[30:0];
    mb     = (b[30:23] == 8'd0) ? 31'd0 : b[30:0];
    big    = (ma >= mb) ? a : b;
    lesser = (ma >= mb) ? b : a;
    sig_big   = (big[30:23] == 8'd0) ? 24'd0 : {1'b1, big[22:0]};
    sig_small = (lesser[30:23] == 8'd0) ? 24'd0 : {1'b1, lesser[22:0]};
    va   = {2'b00, sig_big, 40'd0};  // 40 spare bits below the lsb
    diff = int'(big[30:23]) - int'(lesser[30:23]);
    if (sig_small == 24'd0)
        vb = '0;
    else if (diff > 63)
        vb = 66'd1;                  // far below, sticky only
    else
    begin
        vb   = {2'b00, sig_small, 40'd0} >> diff;
        lost = {2'b00, sig_small, 40'd0} & ((66'd1 << diff) - 66'd1);
        if (lost != '0)
            vb[0] = 1'b1;
    end
    total = (a[31] ^ b[31]) ? va - vb : va + vb;
    if (total == '0)
        return 33'd0;
    lead = find_lead(total);
    r    = round_even(total, lead);
    e    = int'(big[30:23]) + lead - 63 + int'(r[24]);
    if (e >= 255)
        return {1'b1, big[31], 8'hff, 23'd0};
    if (e < 1)
        return {1'b1, 32'd0};
    return {1'b0, big[31], 8'(e), r[22:0]};
endfunction

function automatic logic [32:0] ref_mul(input logic [31:0] a, input logic [31:0] b);
    logic        a_nan, b_nan, a_inf, b_inf, a_zero, b_zero, sign;
    logic [65:0] prod;
    logic [24:0] r;
    int          lead, e;
    a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
    b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
    a_inf  = (a[30:23] == 8'hff) && (a[22:0] == 23'd0);
    b_inf  = (b[30:23] == 8'hff) && (b[22:0] == 23'd0);
    a_zero = (a[30:23] == 8'd0);
    b_zero = (b[30:23] == 8'd0);
    sign   = a[31] ^ b[31];
    if (a_nan || b_nan)
        return {1'b1, 32'(`FPU_NAN_WORD)};
    if ((a_inf && b_zero) || (a_zero && b_inf))
        return {1'b1, 32'(`FPU_NAN_WORD)};
    if (a_inf || b_inf)
        return {1'b1, sign, 8'hff, 23'd0};
    if (a_zero || b_zero)
        return {1'b0, sign, 31'd0};
    prod = 66'({1'b1, a[22:0]}) * 66'({1'b1, b[22:0]});
    lead = find_lead(prod);          // 46 or 47
    r    = round_even(prod, lead);
    e    = int'(a[30:23]) + int'(b[30:23]) - `FPU_EXP_BIAS + (lead - 46) + int'(r[24]);
    if (e >= 255)
        return {1'b1, sign, 8'hff, 23'd0};
    if (e < 1)
        return {1'b1, 32'd0};
    return {1'b0, sign, 8'(e), r[22:0]};
endfunction

`endif

//--- test/tb_fpu.sv
module tb_fpu;
    import fpu_pkg::*;

    `include "fpu_model.svh"

    logic        fpu_clock;
    logic        fpu_reset_b;
    fpu_op_t     fpu_instr;
    reg_index_t  fs, ft, fd;
    fp_word_t    data_gpr;
    fp_word_t    result, data_fpr;
    logic        exception;

    logic [31:0] lfsr_state = 32'h6bb3_06da;
    logic [31:0] shadow [32];          // expected register contents
    int          cycle_count = 0;
    int          exp_cycle_q[$];
    logic [31:0] exp_result_q[$];
    logic        exp_exc_q[$];
    int          result_errors = 0;
    int          exc_errors = 0;
    int          fpr_errors = 0;
    int          timeout_errors = 0;

    fpu_top i_fpu_top
    (
        .fpu_clock   (fpu_clock),
        .fpu_reset_b (fpu_reset_b),
        .fpu_instr   (fpu_instr),
        .fs          (fs),
        .ft          (ft),
        .fd          (fd),
        .data_gpr    (data_gpr),
        .result      (result),
        .data_fpr    (data_fpr),
        .exception   (exception)
    );

    initial
    begin
        fpu_clock = 1'b0;
        forever #2 fpu_clock = ~fpu_clock;
    end

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // exponent kept in 100..154
    task automatic rand_word(output logic [31:0] w);
        logic [31:0] s, t, f;
        take_bits(1, s);
        take_bits(8, t);
        take_bits(23, f);
        w = {s[0], 8'(100 + t % 55), f[22:0]};
    endtask

    task automatic issue(input fpu_op_t op, input logic [4:0] s, input logic [4:0] t,
                         input logic [4:0] d, input logic [31:0] gpr);
        logic [32:0] even, odd;
        logic [31:0] res;
        logic        exc;
        @(posedge fpu_clock);
        #1;
        fpu_instr = op;
        fs        = s;
        ft        = t;
        fd        = d;
        data_gpr  = gpr;
        res       = '0;
        exc       = 1'b0;
        case (op)
            op_adds, op_subs, op_muls:
            begin
                if (op == op_muls)
                    even = ref_mul(shadow[s], shadow[t]);
                else
                    even = ref_add(shadow[s], (op == op_subs) ? shadow[t] ^ 32'h8000_0000
                                                               : shadow[t]);
                shadow[d] = even[31:0];
                res       = even[31:0];
                exc       = even[32];
            end
            op_addps, op_subps, op_mulps:
            begin
                if (op == op_mulps)
                begin
                    even = ref_mul(shadow[s], shadow[t]);
                    odd  = ref_mul(shadow[5'(s + 1)], shadow[5'(t + 1)]);
                end
                else
                begin
                    even = ref_add(shadow[s], (op == op_subps) ? shadow[t] ^ 32'h8000_0000
                                                                : shadow[t]);
                    odd  = ref_add(shadow[5'(s + 1)], (op == op_subps)
                                   ? shadow[5'(t + 1)] ^ 32'h8000_0000 : shadow[5'(t + 1)]);
                end
                shadow[d]          = even[31:0];
                shadow[5'(d + 1)]  = odd[31:0];
                res                = odd[31:0];    // lower lane shows
                exc                = even[32] | odd[32];
            end
            op_mtc1: shadow[s] = gpr;
            default: ;
        endcase
        exp_cycle_q.push_back(cycle_count + 1);   // sampled at the next edge
        exp_result_q.push_back(res);
        exp_exc_q.push_back(exc);
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        issue(op_idle, 5'd0, 5'd0, 5'd0, 32'd0);
        while ((exp_cycle_q.size() != 0) && (guard < 16))
        begin
            @(posedge fpu_clock);
            guard++;
        end
        if (exp_cycle_q.size() != 0)
        begin
            timeout_errors++;
            $display("timeout: expected results still pending after %0d cycles", guard);
        end
    endtask

    task automatic read_reg(input logic [4:0] idx);
        logic [31:0] expected;
        expected = shadow[idx];
        issue(op_mfc1, idx, 5'd0, 5'd0, 32'd0);
        issue(op_idle, 5'd0, 5'd0, 5'd0, 32'd0);
        #1;                                        // 2 units past the mfc1 edge
        assert (data_fpr === expected)
        else
        begin
            fpr_errors++;
            $display("CHECK FAILED t=%0t data_fpr(f%0d) got %h expected %h",
                     $time, idx, data_fpr, expected);
        end
    endtask

    // compare process, two edges after sampling
    initial
    begin
        forever
        begin
            @(posedge fpu_clock);
            cycle_count++;
            #2;
            while ((exp_cycle_q.size() != 0) && (exp_cycle_q[0] + 2 <= cycle_count))
            begin
                assert (result === exp_result_q[0])
                else
                begin
                    result_errors++;
                    $display("CHECK FAILED t=%0t result got %h expected %h",
                             $time, result, exp_result_q[0]);
                end
                assert (exception === exp_exc_q[0])
                else
                begin
                    exc_errors++;
                    $display("CHECK FAILED t=%0t exception got %b expected %b",
                             $time, exception, exp_exc_q[0]);
                end
                void'(exp_cycle_q.pop_front());
                void'(exp_result_q.pop_front());
                void'(exp_exc_q.pop_front());
            end
        end
    end

    initial
    begin
        logic [31:0] w, v;
        logic [4:0]  a, b, d;
        fpu_reset_b = 1'b1;
        fpu_instr   = op_idle;
        fs          = '0;
        ft          = '0;
        fd          = '0;
        data_gpr    = '0;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;
        repeat (3) @(posedge fpu_clock);
        #1;
        fpu_reset_b = 1'b0;

        // reset state
        assert ((result === 32'd0) && (exception === 1'b0))
        else
        begin
            result_errors++;
            $display("CHECK FAILED t=%0t result/exception got %h/%b expected 0/0",
                     $time, result, exception);
        end
        for (int i = 0; i < 32; i++)
            read_reg(5'(i));

        // register moves
        for (int i = 0; i < 32; i++)
        begin
            rand_word(w);
            issue(op_mtc1, 5'(i), 5'd0, 5'd0, w);
        end
        drain();
        for (int i = 0; i < 32; i++)
            read_reg(5'(i));

        // singles read 0..15 and write 16..31, no hazards
        for (int i = 0; i < 24; i++)
        begin
            take_bits(2, v);
            take_bits(4, w);
            a = 5'(w);
            take_bits(4, w);
            b = 5'(w);
            take_bits(4, w);
            d = 5'(16 + w);
            issue((v % 3 == 0) ? op_adds : (v % 3 == 1) ? op_subs : op_muls, a, b, d, 32'd0);
        end
        drain();
        for (int i = 16; i < 32; i++)
            read_reg(5'(i));

        // pairs
        for (int i = 0; i < 18; i++)
        begin
            take_bits(2, v);
            take_bits(3, w);
            a = 5'(2 * w);
            take_bits(3, w);
            b = 5'(2 * w);
            take_bits(3, w);
            d = 5'(16 + 2 * w);
            issue((v % 3 == 0) ? op_addps : (v % 3 == 1) ? op_subps : op_mulps, a, b, d, 32'd0);
        end
        drain();
        for (int i = 16; i < 32; i++)
            read_reg(5'(i));

        // special operands
        issue(op_mtc1, 5'd0, 5'd0, 5'd0, 32'h7fc0_0000);   // nan
        issue(op_mtc1, 5'd1, 5'd0, 5'd0, 32'h7f80_0000);   // +inf
        issue(op_mtc1, 5'd2, 5'd0, 5'd0, 32'h0000_0000);
        issue(op_mtc1, 5'd3, 5'd0, 5'd0, 32'h3fc0_0000);   // 1.5
        issue(op_mtc1, 5'd4, 5'd0, 5'd0, 32'h7f00_0000);   // 2^127
        issue(op_mtc1, 5'd5, 5'd0, 5'd0, 32'h0080_0000);   // smallest normal
        issue(op_mtc1, 5'd6, 5'd0, 5'd0, 32'hbfc0_0000);   // -1.5
        drain();
        issue(op_adds, 5'd0, 5'd3, 5'd20, 32'd0);
        issue(op_muls, 5'd3, 5'd0, 5'd21, 32'd0);
        issue(op_adds, 5'd1, 5'd3, 5'd22, 32'd0);
        issue(op_muls, 5'd1, 5'd2, 5'd23, 32'd0);
        issue(op_muls, 5'd1, 5'd6, 5'd24, 32'd0);
        issue(op_muls, 5'd4, 5'd4, 5'd25, 32'd0);
        issue(op_muls, 5'd5, 5'd5, 5'd26, 32'd0);
        issue(op_subs, 5'd3, 5'd3, 5'd27, 32'd0);
        issue(op_adds, 5'd3, 5'd6, 5'd28, 32'd0);
        drain();
        for (int i = 20; i < 29; i++)
            read_reg(5'(i));

        // dropped opcodes act as idle
        for (int k = 7; k <= 12; k++)
            issue(fpu_op_t'(k), 5'd3, 5'd6, 5'(k + 8), 32'd0);
        drain();
        for (int k = 7; k <= 12; k++)
            read_reg(5'(k + 8));
        drain();

        $display("errors: result %0d exception %0d data_fpr %0d timeout %0d",
                 result_errors, exc_errors, fpr_errors, timeout_errors);
        if ((result_errors + exc_errors + fpr_errors + timeout_errors) == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // whole-run limit
    initial
    begin
        #20000;
        $display("timeout: simulation did not reach its end");
        $display("sim failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+design
+incdir+test
design/fpu_pkg.sv
design/fp_adder.sv
design/fp_multiplier.sv
design/fp_execute.sv
design/fpr_file.sv
design/fpu_top.sv
test/tb_fpu.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_fpu
FILE_LIST = list.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
